//--- clk_mon_top.f
+incdir+hw
hw/clk_mon_pkg.sv
hw/gate_timer.sv
hw/flag_sync.sv
hw/clk_counter.sv
hw/clk_mon_regs.sv
hw/clk_mon_top.sv
dv/clk_mon_asserts.sv
dv/clk_mon_tb.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := clk_mon_tb
FILELIST := clk_mon_top.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
FAIL_MSG := FAIL: see errors above

SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST))) hw/clk_mon_consts.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/clk_mon_tb.sv
`timescale 1ns/100ps
`include "clk_mon_consts.svh"

module clk_mon_tb;

    import clk_mon_pkg::*;

    localparam int PS_PERIOD_NS  = 40;
    localparam int ADC_PERIOD_NS = 28;
    localparam int REF_PERIOD_NS = 100;
    localparam int DRIVE_DELAY   = 2;
    localparam int ACK_TIMEOUT   = 4;
    localparam int SEQ_TIMEOUT   = 4 * `CLK_MON_GATE_TICKS;    // In ps_clk cycles
    localparam int FREQ_TOL      = 2;
    localparam int unsigned RAND_SEED = 32'h5f1c_17a6;

    logic                       ps_clk;
    logic                       rst_i;
    logic                       adc_clk_i;
    logic                       ref_clk_i;
    logic                       bus_stb_i;
    logic                       bus_we_i;
    logic [`CLK_MON_ADDR_W-1:0] bus_adr_i;
    bus_data_t                  bus_dat_i;
    bus_data_t                  bus_dat_o;
    logic                       bus_ack_o;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_passed = 0;
    bit    timed_out = 1'b0;
    freq_t adc_expected;
    freq_t ref_expected;

    clk_mon_top i_clk_mon_top (
        .ps_clk    (ps_clk),
        .rst_i     (rst_i),
        .adc_clk_i (adc_clk_i),
        .ref_clk_i (ref_clk_i),
        .bus_stb_i (bus_stb_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o)
    );

    initial begin
        ps_clk = 1'b0;
        forever #(PS_PERIOD_NS / 2) ps_clk = ~ps_clk;
    end

    initial begin
        adc_clk_i = 1'b0;
        forever #(ADC_PERIOD_NS / 2) adc_clk_i = ~adc_clk_i;
    end

    initial begin
        ref_clk_i = 1'b0;
        forever #(REF_PERIOD_NS / 2) ref_clk_i = ~ref_clk_i;
    end

    // Edges of the measured clock per gate window
    function automatic freq_t expected_count(input int gate_ticks, input int ps_period,
                                             input int meas_period);
        return freq_t'((gate_ticks * ps_period) / meas_period);
    endfunction

    task automatic check_freq(input string what, input freq_t got, input freq_t expected);
        longint diff;
        diff = longint'(got) - longint'(expected);
        if (diff > FREQ_TOL || diff < -FREQ_TOL) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d +/- %0d",
                     $time, what, got, expected, FREQ_TOL);
            errors++;
        end
    endtask

    task automatic check_seq(input string what, input seq_t got, input seq_t expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input bus_data_t got,
                              input bus_data_t expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
            errors++;
        end
    endtask

    // Called 2 ns after an edge with the strobe already dropped
    task automatic wait_ack();
        int waited;
        waited = 0;
        while (!bus_ack_o && waited < ACK_TIMEOUT) begin
            @(posedge ps_clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!bus_ack_o) begin
            $display("ERROR at %0t: no acknowledge from the register port", $time);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_read(input reg_addr_t adr, output bus_data_t data);
        bus_stb_i = 1'b1;
        bus_we_i  = 1'b0;
        bus_adr_i = adr;
        @(posedge ps_clk);
        #DRIVE_DELAY;
        bus_stb_i = 1'b0;
        wait_ack();
        data = bus_dat_o;
    endtask

    task automatic bus_write(input reg_addr_t adr, input bus_data_t data);
        bus_stb_i = 1'b1;
        bus_we_i  = 1'b1;
        bus_adr_i = adr;
        bus_dat_i = data;
        @(posedge ps_clk);
        #DRIVE_DELAY;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        wait_ack();
    endtask

    // Polls status once per cycle until both counts reach their targets
    task automatic wait_seq(input seq_t adc_target, input seq_t ref_target,
                            output seq_t adc_seq, output seq_t ref_seq);
        bus_data_t status;
        int        polls;
        polls   = 0;
        adc_seq = '0;
        ref_seq = '0;
        do begin
            bus_read(REG_STATUS, status);
            if (timed_out) return;
            adc_seq = status[31:16];
            ref_seq = status[15:0];
            polls++;
        end while ((adc_seq < adc_target || ref_seq < ref_target) && polls < SEQ_TIMEOUT);
        if (adc_seq < adc_target || ref_seq < ref_target) begin
            $display("ERROR at %0t: no new measurement arrived within 4 gate periods", $time);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic read_freqs(output freq_t adc_f, output freq_t ref_f);
        bus_data_t d;
        if ($urandom % 2 == 0) begin
            bus_read(REG_ADC_FREQ, d);
            adc_f = d;
            bus_read(REG_REF_FREQ, d);
            ref_f = d;
        end else begin
            bus_read(REG_REF_FREQ, d);
            ref_f = d;
            bus_read(REG_ADC_FREQ, d);
            adc_f = d;
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            tests_passed++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            $display("[%0t] %s: %0d errors", $time, name, errors - start_errors);
        end
    endtask

    // Back to back reads that finish before the first capture lands
    task automatic reset_values();
        bus_data_t d;
        bus_read(REG_ADC_FREQ, d);
        check_data("adc freq after reset", d, '0);
        bus_read(REG_REF_FREQ, d);
        check_data("ref freq after reset", d, '0);
        bus_read(REG_STATUS, d);
        check_data("status after reset", d, '0);
        bus_read(REG_CTRL, d);
        check_data("ctrl after reset", d, '0);
    endtask

    task automatic first_measurement();
        seq_t  adc_seq;
        seq_t  ref_seq;
        freq_t adc_f;
        freq_t ref_f;
        wait_seq(16'd2, 16'd2, adc_seq, ref_seq);
        if (timed_out) return;
        read_freqs(adc_f, ref_f);
        check_freq("adc freq", adc_f, adc_expected);
        check_freq("ref freq", ref_f, ref_expected);
    endtask

    task automatic five_gates();
        bus_data_t status;
        seq_t      adc_base;
        seq_t      ref_base;
        seq_t      adc_seq;
        seq_t      ref_seq;
        freq_t     adc_f;
        freq_t     ref_f;
        int        i;
        bus_read(REG_STATUS, status);
        adc_base = status[31:16];
        ref_base = status[15:0];
        for (i = 1; i <= 5; i++) begin
            wait_seq(adc_base + seq_t'(i), ref_base + seq_t'(i), adc_seq, ref_seq);
            if (timed_out) return;
            check_seq("adc seq", adc_seq, adc_base + seq_t'(i));
            check_seq("ref seq", ref_seq, ref_base + seq_t'(i));
            read_freqs(adc_f, ref_f);
            check_freq("adc freq", adc_f, adc_expected);
            check_freq("ref freq", ref_f, ref_expected);
        end
    endtask

    task automatic restart_clears();
        bus_data_t d;
        seq_t      adc_seq;
        seq_t      ref_seq;
        freq_t     adc_f;
        freq_t     ref_f;
        bus_write(REG_CTRL, 32'h0000_0001);
        bus_read(REG_STATUS, d);
        check_data("status after restart", d, '0);
        read_freqs(adc_f, ref_f);
        check_data("adc freq after restart", adc_f, '0);
        check_data("ref freq after restart", ref_f, '0);
        // First capture covers a partial window and the second a full one
        wait_seq(16'd2, 16'd2, adc_seq, ref_seq);
        if (timed_out) return;
        check_seq("adc seq after restart", adc_seq, 16'd2);
        check_seq("ref seq after restart", ref_seq, 16'd2);
        read_freqs(adc_f, ref_f);
        check_freq("adc freq after restart", adc_f, adc_expected);
        check_freq("ref freq after restart", ref_f, ref_expected);
    endtask

    // Runs right after a capture, so no new done lands in between
    task automatic ignored_writes();
        bus_data_t status_before;
        bus_data_t status_after;
        freq_t     adc_before;
        freq_t     ref_before;
        freq_t     adc_after;
        freq_t     ref_after;
        bus_read(REG_STATUS, status_before);
        read_freqs(adc_before, ref_before);
        bus_write(REG_ADC_FREQ, 32'hdead_beef);
        bus_write(REG_STATUS, 32'hffff_ffff);
        bus_read(REG_STATUS, status_after);
        read_freqs(adc_after, ref_after);
        check_seq("adc seq after writes", status_after[31:16], status_before[31:16]);
        check_seq("ref seq after writes", status_after[15:0], status_before[15:0]);
        check_data("adc freq after writes", adc_after, adc_before);
        check_data("ref freq after writes", ref_after, ref_before);
    endtask

    initial begin
        int start_errors;
        int assert_fails;
        rst_i     = 1'b1;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        bus_adr_i = '0;
        bus_dat_i = '0;
        void'($urandom(RAND_SEED));
        adc_expected = expected_count(`CLK_MON_GATE_TICKS, PS_PERIOD_NS, ADC_PERIOD_NS);
        ref_expected = expected_count(`CLK_MON_GATE_TICKS, PS_PERIOD_NS, REF_PERIOD_NS);

        repeat (2) @(posedge ps_clk);
        #DRIVE_DELAY;
        rst_i = 1'b0;

        start_errors = errors;
        reset_values();
        end_test("reset values", start_errors);
        if (!timed_out) begin
            start_errors = errors;
            first_measurement();
            end_test("first full measurement", start_errors);
        end
        if (!timed_out) begin
            start_errors = errors;
            five_gates();
            end_test("five further gates", start_errors);
        end
        if (!timed_out) begin
            start_errors = errors;
            restart_clears();
            end_test("restart clears results", start_errors);
        end
        if (!timed_out) begin
            start_errors = errors;
            ignored_writes();
            end_test("ignored writes", start_errors);
        end

        assert_fails = i_clk_mon_top.i_clk_mon_asserts.fail_count;
        if (assert_fails != 0) begin
            $display("ERROR: %0d bound assertions failed during the run", assert_fails);
            errors += assert_fails;
        end

        $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- dv/clk_mon_asserts.sv
`timescale 1ns/100ps

// Protocol checks on the register port and the gate pulse
module clk_mon_asserts (
    input logic ps_clk,
    input logic rst_i,
    input logic stb_i,
    input logic ack_i,
    input logic gate_i
);

    int fail_count = 0;    // Failed assertions so far

    property ack_follows_stb;
        @(posedge ps_clk) disable iff (rst_i) stb_i |=> ack_i;
    endproperty

    property no_ack_without_stb;
        @(posedge ps_clk) disable iff (rst_i) !stb_i |=> !ack_i;
    endproperty

    // Gate is a single-cycle pulse
    property gate_single_cycle;
        @(posedge ps_clk) gate_i |=> !gate_i;
    endproperty

    property ack_low_after_reset;
        @(posedge ps_clk) rst_i |=> !ack_i;
    endproperty

    a_ack_follows_stb: assert property (ack_follows_stb)
        else begin
            $error("bus_ack_o did not follow bus_stb_i by one cycle");
            fail_count++;
        end

    a_no_ack_without_stb: assert property (no_ack_without_stb)
        else begin
            $error("bus_ack_o high without a strobe in the previous cycle");
            fail_count++;
        end

    a_gate_single_cycle: assert property (gate_single_cycle)
        else begin
            $error("gate pulse high for two cycles in a row");
            fail_count++;
        end

    a_ack_low_after_reset: assert property (ack_low_after_reset)
        else begin
            $error("bus_ack_o high in the cycle after reset");
            fail_count++;
        end

endmodule

bind clk_mon_top clk_mon_asserts i_clk_mon_asserts (
    .ps_clk (ps_clk),
    .rst_i  (rst_i),
    .stb_i  (bus_stb_i),
    .ack_i  (bus_ack_o),
    .gate_i (gate)
);

//--- hw/clk_mon_top.sv
`timescale 1ns/100ps
`include "clk_mon_consts.svh"

// Frequency monitor for the ADC sample clock and the reference clock
module clk_mon_top (
    input  logic                       ps_clk,
    input  logic                       rst_i,
    input  logic                       adc_clk_i,
    input  logic                       ref_clk_i,
    input  logic                       bus_stb_i,
    input  logic                       bus_we_i,
    input  logic [`CLK_MON_ADDR_W-1:0] bus_adr_i,
    input  clk_mon_pkg::bus_data_t     bus_dat_i,
    output clk_mon_pkg::bus_data_t     bus_dat_o,
    output logic                       bus_ack_o
);

    import clk_mon_pkg::*;

    logic  gate;
    logic  restart;
    logic  adc_done;
    logic  ref_done;
    freq_t adc_freq;
    freq_t ref_freq;

    gate_timer i_gate_timer (
        .ps_clk    (ps_clk),
        .rst_i     (rst_i),
        .restart_i (restart),
        .gate_o    (gate)
    );

    // Same gate into both measured domains
    clk_counter i_adc_counter (
        .ps_clk     (ps_clk),
        .meas_clk_i (adc_clk_i),
        .gate_i     (gate),
        .done_o     (adc_done),
        .freq_o     (adc_freq)
    );

    clk_counter i_ref_counter (
        .ps_clk     (ps_clk),
        .meas_clk_i (ref_clk_i),
        .gate_i     (gate),
        .done_o     (ref_done),
        .freq_o     (ref_freq)
    );

    clk_mon_regs i_clk_mon_regs (
        .ps_clk     (ps_clk),
        .rst_i      (rst_i),
        .adc_done_i (adc_done),
        .ref_done_i (ref_done),
        .adc_freq_i (adc_freq),
        .ref_freq_i (ref_freq),
        .bus_stb_i  (bus_stb_i),
        .bus_we_i   (bus_we_i),
        .bus_adr_i  (reg_addr_t'(bus_adr_i)),
        .bus_dat_i  (bus_dat_i),
        .bus_dat_o  (bus_dat_o),
        .bus_ack_o  (bus_ack_o),
        .restart_o  (restart)
    );

endmodule

//--- hw/clk_mon_regs.sv
`timescale 1ns/100ps

// Result capture and strobe register port
module clk_mon_regs (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    input  logic                   adc_done_i,
    input  logic                   ref_done_i,
    input  clk_mon_pkg::freq_t     adc_freq_i,
    input  clk_mon_pkg::freq_t     ref_freq_i,
    input  logic                   bus_stb_i,
    input  logic                   bus_we_i,
    input  clk_mon_pkg::reg_addr_t bus_adr_i,
    input  clk_mon_pkg::bus_data_t bus_dat_i,
    output clk_mon_pkg::bus_data_t bus_dat_o,
    output logic                   bus_ack_o,
    output logic                   restart_o
);

    import clk_mon_pkg::*;

    freq_t     adc_freq_q;
    freq_t     ref_freq_q;
    seq_t      adc_seq_q;
    seq_t      ref_seq_q;
    logic      ctrl_wr;
    bus_data_t rd_data;

    assign ctrl_wr = bus_stb_i && bus_we_i && (bus_adr_i == REG_CTRL) && bus_dat_i[0];

    // Captures, cleared by reset and by a restart write alike
    always_ff @(posedge ps_clk) begin
        if (rst_i || ctrl_wr) begin
            adc_freq_q <= '0;
            ref_freq_q <= '0;
            adc_seq_q  <= '0;
            ref_seq_q  <= '0;
        end else begin
            if (adc_done_i) begin
                adc_freq_q <= adc_freq_i;
                adc_seq_q  <= adc_seq_q + 1'b1;
            end
            if (ref_done_i) begin
                ref_freq_q <= ref_freq_i;
                ref_seq_q  <= ref_seq_q + 1'b1;
            end
        end
    end

    always_comb begin
        unique case (bus_adr_i)
            REG_ADC_FREQ: rd_data = adc_freq_q;
            REG_REF_FREQ: rd_data = ref_freq_q;
            REG_STATUS:   rd_data = {adc_seq_q, ref_seq_q};
            default:      rd_data = '0;
        endcase
    end

    // Ack and restart, one cycle after the strobe
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            bus_ack_o <= 1'b0;
            restart_o <= 1'b0;
        end else begin
            bus_ack_o <= bus_stb_i;
            restart_o <= ctrl_wr;
        end
    end

    // Read data, only meaningful in the ack cycle
    always_ff @(posedge ps_clk) begin
        if (bus_stb_i && !bus_we_i) begin
            bus_dat_o <= rd_data;
        end
    end

endmodule

//--- hw/clk_counter.sv
`timescale 1ns/100ps

// Counts meas_clk_i edges between gates and reports back to ps_clk
module clk_counter (
    input  logic               ps_clk,
    input  logic               meas_clk_i,
    input  logic               gate_i,
    output logic               done_o,
    output clk_mon_pkg::freq_t freq_o
);

    import clk_mon_pkg::*;

    logic gate_meas;           // Gate seen in the measured domain

    // Measured-domain state starts at zero
    freq_t cnt_q  = '0;
    freq_t freq_q = '0;

    flag_sync i_gate_sync (
        .clk_a_i  (ps_clk),
        .clk_b_i  (meas_clk_i),
        .flag_a_i (gate_i),
        .flag_b_o (gate_meas)
    );

    always_ff @(posedge meas_clk_i) begin
        if (gate_meas) begin
            freq_q <= cnt_q;   // Close the window
            cnt_q  <= '0;
        end else begin
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // Sent back the cycle the latch happens, so freq_q is long settled
    // by the time done_o reaches ps_clk
    flag_sync i_done_sync (
        .clk_a_i  (meas_clk_i),
        .clk_b_i  (ps_clk),
        .flag_a_i (gate_meas),
        .flag_b_o (done_o)
    );

    // Held until the next gate and read in ps_clk only on done_o
    assign freq_o = freq_q;

endmodule

//--- hw/flag_sync.sv
`timescale 1ns/100ps

// Pulse crossing between two unrelated clocks
module flag_sync (
    input  logic clk_a_i,
    input  logic clk_b_i,
    input  logic flag_a_i,
    output logic flag_b_o
);

    // Level that flips once per source pulse
    logic toggle_a = 1'b0;

    // Stage 0 is the metastability catcher
    logic [2:0] sync_b = 3'b000;

    always_ff @(posedge clk_a_i) begin
        if (flag_a_i) begin
            toggle_a <= ~toggle_a;
        end
    end

    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    // Any change of the toggle is one pulse in domain B
    assign flag_b_o = sync_b[2] ^ sync_b[1];

endmodule

//--- hw/gate_timer.sv
`timescale 1ns/100ps
`include "clk_mon_consts.svh"

// Free-running window timer, one gate pulse per period
module gate_timer (
    input  logic ps_clk,
    input  logic rst_i,
    input  logic restart_i,
    output logic gate_o
);

    localparam int CNT_W = $clog2(`CLK_MON_GATE_TICKS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`CLK_MON_GATE_TICKS - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge ps_clk) begin
        if (rst_i || restart_i) begin
            cnt_q  <= '0;
            gate_o <= 1'b0;
        end else begin
            // Pulse while the count sits at zero
            gate_o <= (cnt_q == '0);
            if (cnt_q == LAST_CNT) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

//--- hw/clk_mon_pkg.sv
`include "clk_mon_consts.svh"

package clk_mon_pkg;

    typedef logic [`CLK_MON_FREQ_W-1:0] freq_t;

    typedef logic [`CLK_MON_SEQ_W-1:0] seq_t;

    // Register map of the strobe port
    typedef enum logic [`CLK_MON_ADDR_W-1:0] {
        REG_ADC_FREQ = 2'd0,
        REG_REF_FREQ = 2'd1,
        REG_STATUS   = 2'd2,    // {adc seq, ref seq}
        REG_CTRL     = 2'd3     // Bit 0 restarts, reads as zero
    } reg_addr_t;

    typedef logic [31:0] bus_data_t;

endpackage

//--- hw/clk_mon_consts.svh
`ifndef CLK_MON_CONSTS_SVH
`define CLK_MON_CONSTS_SVH

// Measurement window in ps_clk cycles
`define CLK_MON_GATE_TICKS 1000

// Latched edge count
`define CLK_MON_FREQ_W 32

// Per-domain measurement counter, wraps
`define CLK_MON_SEQ_W 16

// Four registers on the strobe port
`define CLK_MON_ADDR_W 2

`endif
